//--- source/mduArithPkg.sv
`default_nettype none

package mduArithPkg;

    ////////////////////
    // Operations
    ////////////////////

    // Command word bits 2:0
    typedef enum logic [2:0] {
        opMult  = 3'd0,
        opMultu = 3'd1,
        opMsub  = 3'd2,
        opDiv   = 3'd3,
        opDivu  = 3'd4
    } mduOp_e;

    // Busy cycles per operation class
    localparam int mulLatency   = 5;
    localparam int divLatency   = 18;
    localparam int latencyWidth = 5;

    ////////////////////
    // HI/LO word
    ////////////////////

    // Multiply view and divide view of the same 64 bits, HI on top
    typedef union packed {
        logic signed [63:0] prod;
        struct packed {
            logic [31:0] remainder;
            logic [31:0] quotient;
        } div;
    } hiLo_u;

endpackage

`default_nettype wire

//--- source/mduRegMapPkg.sv
`default_nettype none

package mduRegMapPkg;

    // Byte offsets inside the unit
    localparam int regAddrWidth = 5;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam logic [regAddrWidth-1:0] regOperandA = 5'h00;
    localparam logic [regAddrWidth-1:0] regOperandB = 5'h04;
    // Bits 2:0 select the operation
    localparam logic [regAddrWidth-1:0] regCommand  = 5'h08;
    localparam logic [regAddrWidth-1:0] regHi       = 5'h0C;
    localparam logic [regAddrWidth-1:0] regLo       = 5'h10;
    // Bit 0 is busy
    localparam logic [regAddrWidth-1:0] regStatus   = 5'h14;

endpackage

`default_nettype wire

//--- source/mduApbSlave.sv
`timescale 1ns/100ps
`default_nettype none

module mduApbSlave (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  psel,
    input  wire logic                                  penable,
    input  wire logic                                  pwrite,
    input  wire logic [mduRegMapPkg::regAddrWidth-1:0] paddr,
    input  wire logic [31:0]                           pwdata,
    input  wire logic                                  busy,
    input  wire logic [31:0]                           rdata,
    output logic [31:0]                                prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    output logic                                       start,
    output mduArithPkg::mduOp_e                        op,
    output logic [31:0]                                operandA,
    output logic [31:0]                                operandB,
    output logic                                       hiWrite,
    output logic                                       loWrite,
    output logic [31:0]                                wdata,
    output logic [mduRegMapPkg::regAddrWidth-1:0]      readAddr,
    output logic                                       readEnable
);
    import mduArithPkg::*;
    import mduRegMapPkg::*;

    logic accessPhase;
    logic mapped;
    logic badCommand;
    logic stall;
    logic writeDone;

    assign accessPhase = psel && penable;

    // Offset decode
    always_comb begin
        case (paddr)
            regOperandA, regOperandB, regCommand, regHi, regLo, regStatus: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign badCommand = pwrite && (paddr == regCommand) && (pwdata[2:0] > opDivu);

    // Hold off anything that needs or disturbs the result in flight
    always_comb begin
        stall = 1'b0;
        if (busy) begin
            case (paddr)
                regCommand, regHi, regLo: stall = 1'b1;
                regOperandA, regOperandB: stall = pwrite;
                default: stall = 1'b0;
            endcase
        end
    end

    ////////////////////
    // APB response
    ////////////////////

    assign pready    = accessPhase && !stall;
    assign pslverr   = pready && (!mapped || badCommand);
    assign writeDone = pready && pwrite && !pslverr;
    assign prdata    = rdata;

    // Core launch, one cycle on the completing edge
    assign start = writeDone && (paddr == regCommand);
    assign op    = mduOp_e'(pwdata[2:0]);

    // Bank side
    assign hiWrite    = writeDone && (paddr == regHi);
    assign loWrite    = writeDone && (paddr == regLo);
    assign wdata      = pwdata;
    assign readAddr   = paddr;
    assign readEnable = pready && !pwrite;

    // Operand registers
    always_ff @(posedge clk) begin
        if (reset) begin
            operandA <= '0;
            operandB <= '0;
        end else if (writeDone) begin
            if (paddr == regOperandA) begin
                operandA <= pwdata;
            end
            if (paddr == regOperandB) begin
                operandB <= pwdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mulDivCore.sv
`timescale 1ns/100ps
`default_nettype none

module mulDivCore (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire mduArithPkg::mduOp_e op,
    input  wire logic [31:0]         operandA,
    input  wire logic [31:0]         operandB,
    input  wire mduArithPkg::hiLo_u  hiLo,
    output logic                     busy,
    output logic                     resultValid,
    output mduArithPkg::hiLo_u       result
);
    import mduArithPkg::*;

    logic [latencyWidth-1:0] count;
    logic [latencyWidth-1:0] loadCount;
    logic signed [63:0]      aExt;
    logic signed [63:0]      bExt;
    logic signed [63:0]      signedProd;
    logic [63:0]             unsignedProd;
    logic [31:0]             quotient;
    logic [31:0]             remainder;
    hiLo_u                   nextResult;

    ////////////////////
    // Multiply
    ////////////////////

    assign aExt         = {{32{operandA[31]}}, operandA};
    assign bExt         = {{32{operandB[31]}}, operandB};
    assign signedProd   = aExt * bExt;
    assign unsignedProd = {32'b0, operandA} * {32'b0, operandB};

    ////////////////////
    // Divide
    ////////////////////

    always_comb begin
        if (operandB == '0) begin
            // Divide by zero gives all ones and keeps the dividend
            quotient  = '1;
            remainder = operandA;
        end else if (op == opDiv) begin
            if ((operandA == 32'h8000_0000) && (operandB == '1)) begin
                quotient  = 32'h8000_0000;
                remainder = '0;
            end else begin
                // Truncates toward zero, remainder follows the dividend
                quotient  = $signed(operandA) / $signed(operandB);
                remainder = $signed(operandA) % $signed(operandB);
            end
        end else begin
            quotient  = operandA / operandB;
            remainder = operandA % operandB;
        end
    end

    // Result in the view the operation needs
    always_comb begin
        nextResult.prod = '0;
        loadCount       = latencyWidth'(mulLatency);
        case (op)
            opMult:  nextResult.prod = signedProd;
            opMultu: nextResult.prod = unsignedProd;
            opMsub:  nextResult.prod = hiLo.prod - signedProd;
            opDiv, opDivu: begin
                nextResult.div.quotient  = quotient;
                nextResult.div.remainder = remainder;
                loadCount                = latencyWidth'(divLatency);
            end
            default: nextResult.prod = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= nextResult;
        end
    end

    // Latency countdown
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= loadCount;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy        = (count != '0);
    assign resultValid = (count == latencyWidth'(1));

endmodule

`default_nettype wire

//--- source/hiLoBank.sv
`timescale 1ns/100ps
`default_nettype none

module hiLoBank (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  hiWrite,
    input  wire logic                                  loWrite,
    input  wire logic [31:0]                           wdata,
    input  wire logic                                  resultValid,
    input  wire mduArithPkg::hiLo_u                    result,
    input  wire logic                                  busy,
    input  wire logic [mduRegMapPkg::regAddrWidth-1:0] readAddr,
    input  wire logic                                  readEnable,
    output mduArithPkg::hiLo_u                         hiLo,
    output logic [31:0]                                rdata
);
    import mduArithPkg::*;
    import mduRegMapPkg::*;

    hiLo_u acc;

    ////////////////////
    // HI/LO storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            acc.prod <= '0;
        end else if (resultValid) begin
            acc <= result;
        end else begin
            // Move to HI and move to LO
            if (hiWrite) begin
                acc.prod[63:32] <= wdata;
            end
            if (loWrite) begin
                acc.prod[31:0] <= wdata;
            end
        end
    end

    assign hiLo = acc;

    ////////////////////
    // Read data
    ////////////////////

    // Operands and command read back as zero
    always_comb begin
        rdata = '0;
        if (readEnable) begin
            case (readAddr)
                regHi:     rdata = acc.prod[63:32];
                regLo:     rdata = acc.prod[31:0];
                regStatus: rdata = {31'b0, busy};
                default:   rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mduTop.sv
`timescale 1ns/100ps
`default_nettype none

module mduTop (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  psel,
    input  wire logic                                  penable,
    input  wire logic                                  pwrite,
    input  wire logic [mduRegMapPkg::regAddrWidth-1:0] paddr,
    input  wire logic [31:0]                           pwdata,
    output logic [31:0]                                prdata,
    output logic                                       pready,
    output logic                                       pslverr
);
    import mduArithPkg::*;
    import mduRegMapPkg::*;

    // Slave to core
    logic        start;
    mduOp_e      op;
    logic [31:0] operandA;
    logic [31:0] operandB;

    // Slave to bank
    logic                    hiWrite;
    logic                    loWrite;
    logic [31:0]             wdata;
    logic [regAddrWidth-1:0] readAddr;
    logic                    readEnable;
    logic [31:0]             rdata;

    // Core and bank
    logic  busy;
    logic  resultValid;
    hiLo_u result;
    hiLo_u hiLo;

    mduApbSlave slave_i (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .rdata      (rdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .op         (op),
        .operandA   (operandA),
        .operandB   (operandB),
        .hiWrite    (hiWrite),
        .loWrite    (loWrite),
        .wdata      (wdata),
        .readAddr   (readAddr),
        .readEnable (readEnable)
    );

    mulDivCore core_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .operandA    (operandA),
        .operandB    (operandB),
        .hiLo        (hiLo),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    hiLoBank bank_i (
        .clk         (clk),
        .reset       (reset),
        .hiWrite     (hiWrite),
        .loWrite     (loWrite),
        .wdata       (wdata),
        .resultValid (resultValid),
        .result      (result),
        .busy        (busy),
        .readAddr    (readAddr),
        .readEnable  (readEnable),
        .hiLo        (hiLo),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

//--- verification/mduApb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mduApbChecker (
    input wire logic clk,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr,
    input wire logic start,
    input wire logic busy
);

    // pready only answers an access phase
    readyInAccess: assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    // One operation in flight
    noStartWhileBusy: assert property (@(posedge clk) disable iff (reset) !(start && busy))
        else $error("start raised while the core was busy");

    errorWithReady: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
        else $error("pslverr high without pready");

endmodule

bind mduApbSlave mduApbChecker checker_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .busy    (busy)
);

`default_nettype wire

//--- verification/mduTb.sv
`timescale 1ns/100ps
`default_nettype none

module mduTb;
    import mduArithPkg::*;
    import mduRegMapPkg::*;

    // 200 commands at 60 cycles each
    localparam int timeoutCycles = 200 * 60;

    logic                    clk;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [regAddrWidth-1:0] paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    int unsigned cycles = 0;
    logic [63:0] model;
    string       nameQ[$];
    logic [31:0] expectQ[$];
    logic [31:0] observedQ[$];

    mduTop dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            failRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [63:0] expectHiLo(input logic [2:0] op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [63:0] acc);
        logic [31:0] magA;
        logic [31:0] magB;
        logic [63:0] mag;
        logic [63:0] sprod;
        logic [31:0] q;
        logic [31:0] r;
        logic [63:0] res;
        magA  = a[31] ? -a : a;
        magB  = b[31] ? -b : b;
        mag   = {32'b0, magA} * {32'b0, magB};
        sprod = (a[31] ^ b[31]) ? -mag : mag;
        case (op)
            opMult:  res = sprod;
            opMultu: res = {32'b0, a} * {32'b0, b};
            opMsub:  res = acc - sprod;
            default: begin
                if (b == 32'd0) begin
                    q = 32'hffff_ffff;
                    r = a;
                end else if (op == opDiv) begin
                    // Divide magnitudes and take the remainder sign from the dividend
                    q = magA / magB;
                    r = magA % magB;
                    q = (a[31] ^ b[31]) ? -q : q;
                    r = a[31] ? -r : r;
                end else begin
                    q = a / b;
                    r = a % b;
                end
                res = {r, q};
            end
        endcase
        return res;
    endfunction

    ////////////////////
    // APB tasks
    ////////////////////

    // Called 2 ns after an edge and samples pready at the falling edge
    task automatic apbTransfer(input logic write, input logic [regAddrWidth-1:0] addr,
                               input logic [31:0] data, output logic [31:0] readData,
                               output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        readData = prdata;
        err      = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [regAddrWidth-1:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] ignored;
        logic        err;
        apbTransfer(1'b1, addr, data, ignored, err);
        assert (err == expErr)
            else failRun($sformatf("** Error: pslverr on write to %h is %h, expected %h",
                                   addr, err, expErr));
    endtask

    task automatic apbRead(input logic [regAddrWidth-1:0] addr, output logic [31:0] data,
                           input logic expErr);
        logic err;
        apbTransfer(1'b0, addr, 32'd0, data, err);
        assert (err == expErr)
            else failRun($sformatf("** Error: pslverr on read of %h is %h, expected %h",
                                   addr, err, expErr));
    endtask

    task automatic runOp(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
        apbWrite(regOperandA, a, 1'b0);
        apbWrite(regOperandB, b, 1'b0);
        apbWrite(regCommand, {29'b0, op}, 1'b0);
        model = expectHiLo(op, a, b, model);
    endtask

    // Reads stall until the core is done
    task automatic checkHiLo();
        logic [31:0] hi;
        logic [31:0] lo;
        apbRead(regHi, hi, 1'b0);
        apbRead(regLo, lo, 1'b0);
        nameQ.push_back("prdata (HI)");
        expectQ.push_back(model[63:32]);
        observedQ.push_back(hi);
        nameQ.push_back("prdata (LO)");
        expectQ.push_back(model[31:0]);
        observedQ.push_back(lo);
    endtask

    // Compares queued HI/LO reads with the model
    always @(negedge clk) begin
        while (observedQ.size() > 0) begin
            assert (observedQ[0] === expectQ[0])
                else failRun($sformatf("** Error: %s is %h, expected %h",
                                       nameQ[0], observedQ[0], expectQ[0]));
            void'(nameQ.pop_front());
            void'(expectQ.pop_front());
            void'(observedQ.pop_front());
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        int unsigned t0;
        int          polls;
        void'($urandom(32'hbadd678c));
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        model   = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        apbRead(regStatus, data, 1'b0);
        assert (data == 32'd0)
            else failRun($sformatf("** Error: prdata (status) after reset is %h, expected 0",
                                   data));
        checkHiLo();

        // Multiplies
        repeat (40) begin
            runOp((($urandom & 1) != 0) ? opMultu : opMult, $urandom, $urandom);
            checkHiLo();
        end

        // Multiply-subtract chains from a written accumulator
        repeat (3) begin
            a = $urandom;
            b = $urandom;
            apbWrite(regHi, a, 1'b0);
            apbWrite(regLo, b, 1'b0);
            model = {a, b};
            checkHiLo();
            repeat (8) begin
                runOp(opMsub, $urandom, $urandom);
                checkHiLo();
            end
        end

        // Divides with every eighth divisor zero
        for (int i = 0; i < 40; i++) begin
            b = (i % 8 == 0) ? 32'd0 : ($urandom >> ($urandom % 32));
            runOp((($urandom & 1) != 0) ? opDivu : opDiv, $urandom, b);
            checkHiLo();
        end
        runOp(opDiv, 32'h8000_0000, 32'hffff_ffff);
        checkHiLo();
        runOp(opDiv, 32'hffff_fff9, 32'd2);
        checkHiLo();
        runOp(opDiv, 32'd7, 32'hffff_fffe);
        checkHiLo();
        runOp(opDivu, 32'h8000_0000, 32'hffff_ffff);
        checkHiLo();
        runOp(opDiv, 32'h8000_0000, 32'd0);
        checkHiLo();

        // Busy polling and a command held off while busy
        a = $urandom;
        b = $urandom;
        runOp(opDiv, a, b);
        apbRead(regStatus, data, 1'b0);
        assert (data == 32'd1)
            else failRun($sformatf("** Error: prdata (status) after divide is %h, expected 1",
                                   data));
        t0 = cycles;
        apbWrite(regCommand, {29'b0, opMult}, 1'b0);
        assert (cycles - t0 > 2)
            else failRun("A command written while busy completed without a stall");
        model = expectHiLo(opMult, a, b, model);
        polls = 0;
        do begin
            apbRead(regStatus, data, 1'b0);
            polls++;
        end while (data[0] && polls < 20);
        assert (data == 32'd0)
            else failRun("Busy never cleared after the command");
        checkHiLo();

        // Unmapped offset and bad command
        apbRead(5'h18, data, 1'b1);
        apbWrite(5'h18, $urandom, 1'b1);
        apbWrite(regCommand, 32'd7, 1'b1);
        apbRead(regStatus, data, 1'b0);
        assert (data == 32'd0)
            else failRun($sformatf("** Error: prdata (status) after bad command is %h, expected 0",
                                   data));
        checkHiLo();

        repeat (2) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/mduArithPkg.sv
source/mduRegMapPkg.sv
source/mduApbSlave.sv
source/mulDivCore.sv
source/hiLoBank.sv
source/mduTop.sv
verification/mduApb_checker.sv
verification/mduTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mduTb
FILELIST  := build.f
OBJDIR    := obj_dir
PASS      := Testbench passed

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@output="$$($(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
